//--- panel_pkg.sv
// Shared constants and types for the front-panel display path.
// Other files refer to these by scoped name, for example panel_pkg::st_f0.
`default_nettype none

package panel_pkg;

    // Bus widths for the host register interface
    localparam int addr_w = 4;
    localparam int data_w = 32;

    // Width of the display selection field
    localparam int dsel_w = 3;

    // Major-state codes from the CPU core
    localparam logic [4:0] st_f0   = 5'd0;
    localparam logic [4:0] st_fw   = 5'd1;
    localparam logic [4:0] st_f1   = 5'd2;
    localparam logic [4:0] st_f2   = 5'd3;
    localparam logic [4:0] st_f3   = 5'd4;
    localparam logic [4:0] st_f2a  = 5'd5;
    localparam logic [4:0] st_f2b  = 5'd6;
    localparam logic [4:0] st_d0   = 5'd8;
    localparam logic [4:0] st_dw   = 5'd9;
    localparam logic [4:0] st_d1   = 5'd10;
    localparam logic [4:0] st_d2   = 5'd11;
    localparam logic [4:0] st_d3   = 5'd12;
    localparam logic [4:0] st_e0   = 5'd16;
    localparam logic [4:0] st_ew   = 5'd17;
    localparam logic [4:0] st_e1   = 5'd18;
    localparam logic [4:0] st_e2   = 5'd19;
    localparam logic [4:0] st_e3   = 5'd20;
    localparam logic [4:0] st_eae0 = 5'd21;
    localparam logic [4:0] st_eae1 = 5'd22;
    localparam logic [4:0] st_halt = 5'd31;

    // Display selection codes, 6 and 7 fall back to the state word
    localparam logic [dsel_w-1:0] dsel_state  = 3'd0;
    localparam logic [dsel_w-1:0] dsel_status = 3'd1;
    localparam logic [dsel_w-1:0] dsel_ac     = 3'd2;
    localparam logic [dsel_w-1:0] dsel_mb     = 3'd3;
    localparam logic [dsel_w-1:0] dsel_mq     = 3'd4;
    localparam logic [dsel_w-1:0] dsel_io     = 3'd5;

    // Select indicator lamps, one row bit in [4:3] and one column bit in [2:0]
    localparam logic [4:0] led_state  = 5'b01100;
    localparam logic [4:0] led_status = 5'b01010;
    localparam logic [4:0] led_ac     = 5'b01001;
    localparam logic [4:0] led_mb     = 5'b10100;
    localparam logic [4:0] led_mq     = 5'b10010;
    localparam logic [4:0] led_io     = 5'b10001;

    // Register map
    localparam logic [addr_w-1:0] reg_ctrl  = 4'h0;
    localparam logic [addr_w-1:0] reg_lamps = 4'h4;

    typedef struct packed {
        logic [4:0]  state;
        logic [8:0]  state1;
        logic [11:0] status;
        logic [11:0] ac;
        logic [11:0] mb;
        logic [11:0] mq;
        logic [11:0] io_bus;
        logic        run_ff;
        logic        sw_active;
    } cpu_view_t;

    typedef struct packed {
        logic fs;
        logic ds;
        logic es;
    } major_flags_t;

    // Field order matches the reg_lamps bit layout
    typedef struct packed {
        logic        run_led;
        logic [4:0]  dsel_led;
        logic [11:0] dout;
    } panel_lamps_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [addr_w-1:0] paddr;
        logic [data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    localparam int lamps_w = $bits(panel_lamps_t);

endpackage

`default_nettype wire

//--- major_state_decode.sv
// Turns the CPU major-state code into the Fetch, Defer and Execute lamp flags.
// Flags are registered and follow the state code by one clock.
`default_nettype none

module major_state_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              state,
    input  logic                    run_ff,
    output panel_pkg::major_flags_t flags
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else begin
            case (state)
                // Fetch lamp tracks the run flip-flop in F0 and the others hold
                panel_pkg::st_f0: begin
                    flags.fs <= run_ff;
                end
                panel_pkg::st_fw,
                panel_pkg::st_f1,
                panel_pkg::st_f2,
                panel_pkg::st_f3,
                panel_pkg::st_f2a,
                panel_pkg::st_f2b: begin
                    flags.fs <= 1'b1;
                    flags.ds <= 1'b0;
                    flags.es <= 1'b0;
                end
                panel_pkg::st_d0,
                panel_pkg::st_dw,
                panel_pkg::st_d1,
                panel_pkg::st_d2,
                panel_pkg::st_d3: begin
                    flags.fs <= 1'b0;
                    flags.ds <= 1'b1;
                    flags.es <= 1'b0;
                end
                // EAE cycles count as execute
                panel_pkg::st_e0,
                panel_pkg::st_ew,
                panel_pkg::st_e1,
                panel_pkg::st_e2,
                panel_pkg::st_e3,
                panel_pkg::st_eae0,
                panel_pkg::st_eae1: begin
                    flags.fs <= 1'b0;
                    flags.ds <= 1'b0;
                    flags.es <= 1'b1;
                end
                // Halt and every undefined code darken all three lamps
                default: begin
                    flags <= '0;
                end
            endcase
        end
    end

    // Any state other than F0 leaves at most one lamp lit on the next clock
    a_flags_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state != panel_pkg::st_f0) |=> $onehot0(flags)
    ) else $error("major_state_decode: more than one of fs/ds/es set (%b)", flags);

endmodule

`default_nettype wire

//--- display_mux.sv
// Selects one of six CPU words for the data lamps and lights the matching indicators.
// All lamp outputs are registered one clock after their inputs.
`default_nettype none

module display_mux (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [panel_pkg::dsel_w-1:0]       dsel,
    input  panel_pkg::major_flags_t            flags,
    input  panel_pkg::cpu_view_t               cpu_view,
    output panel_pkg::panel_lamps_t            lamps
);

    logic [11:0] word_nxt;
    logic [4:0]  led_nxt;
    logic [11:0] state_word;

    // State word reads F D E first, then the nine bits of state1
    assign state_word = {flags.fs, flags.ds, flags.es, cpu_view.state1};

    always_comb begin
        case (dsel)
            panel_pkg::dsel_status: begin
                word_nxt = cpu_view.status;
                led_nxt  = panel_pkg::led_status;
            end
            panel_pkg::dsel_ac: begin
                word_nxt = cpu_view.ac;
                led_nxt  = panel_pkg::led_ac;
            end
            panel_pkg::dsel_mb: begin
                word_nxt = cpu_view.mb;
                led_nxt  = panel_pkg::led_mb;
            end
            panel_pkg::dsel_mq: begin
                word_nxt = cpu_view.mq;
                led_nxt  = panel_pkg::led_mq;
            end
            panel_pkg::dsel_io: begin
                word_nxt = cpu_view.io_bus;
                led_nxt  = panel_pkg::led_io;
            end
            // dsel_state and the two spare codes
            default: begin
                word_nxt = state_word;
                led_nxt  = panel_pkg::led_state;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lamps <= '0;
        end else begin
            lamps.dout     <= word_nxt;
            lamps.dsel_led <= led_nxt;
            // RUN is inverted while a panel switch is held
            lamps.run_led  <= cpu_view.run_ff ^ cpu_view.sw_active;
        end
    end

    // Once out of reset the indicators always show one row and one column
    a_led_pattern: assert property (
        @(posedge clk) disable iff (!rst_n)
        1'b1 |=> ($onehot(lamps.dsel_led[4:3]) && $onehot(lamps.dsel_led[2:0]))
    ) else $error("display_mux: bad indicator pattern %b", lamps.dsel_led);

endmodule

`default_nettype wire

//--- panel_apb_regs.sv
// APB slave for the front panel with a display-select register and a read-only lamp word.
// It adds no wait states, and read data and pslverr are valid in the access cycle.
`default_nettype none

module panel_apb_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  panel_pkg::apb_req_t          apb,
    output panel_pkg::apb_rsp_t          apb_rsp,
    input  panel_pkg::panel_lamps_t      lamps,
    output logic [panel_pkg::dsel_w-1:0] dsel
);

    logic access;
    logic hit_ctrl;
    logic hit_lamps;
    logic wr_ctrl;

    assign access    = apb.psel && apb.penable;
    assign hit_ctrl  = (apb.paddr == panel_pkg::reg_ctrl);
    assign hit_lamps = (apb.paddr == panel_pkg::reg_lamps);
    assign wr_ctrl   = access && apb.pwrite && hit_ctrl;

    // Selection register, loaded at the edge that ends the access cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dsel <= panel_pkg::dsel_state;
        end else if (wr_ctrl) begin
            dsel <= apb.pwdata[panel_pkg::dsel_w-1:0];
        end
    end

    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = 1'b0;
        if (access) begin
            if (hit_ctrl) begin
                if (!apb.pwrite) begin
                    apb_rsp.prdata = {{(panel_pkg::data_w - panel_pkg::dsel_w){1'b0}}, dsel};
                end
            end else if (hit_lamps) begin
                // The lamp word cannot be written
                if (apb.pwrite) begin
                    apb_rsp.pslverr = 1'b1;
                end else begin
                    apb_rsp.prdata = {{(panel_pkg::data_w - panel_pkg::lamps_w){1'b0}}, lamps};
                end
            end else begin
                apb_rsp.pslverr = 1'b1;
            end
        end
    end

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rst_n)
        apb.penable |-> apb.psel
    ) else $error("panel_apb_regs: penable high without psel");

endmodule

`default_nettype wire

//--- front_panel.sv
// Top of the front-panel display path: state decode, lamp mux and APB registers.
// CPU state comes in as one struct and the lamps leave as one struct.
`default_nettype none

module front_panel (
    input  logic                    clk,
    input  logic                    rst_n,
    input  panel_pkg::cpu_view_t    cpu_view,
    input  panel_pkg::apb_req_t     apb,
    output panel_pkg::apb_rsp_t     apb_rsp,
    output panel_pkg::panel_lamps_t lamps
);

    panel_pkg::major_flags_t        flags;
    logic [panel_pkg::dsel_w-1:0]   dsel;

    major_state_decode major_state_decode_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .state  (cpu_view.state),
        .run_ff (cpu_view.run_ff),
        .flags  (flags)
    );

    display_mux display_mux_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .dsel     (dsel),
        .flags    (flags),
        .cpu_view (cpu_view),
        .lamps    (lamps)
    );

    // Lamps loop back so the host can read what the panel shows
    panel_apb_regs panel_apb_regs_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb     (apb),
        .apb_rsp (apb_rsp),
        .lamps   (lamps),
        .dsel    (dsel)
    );

endmodule

`default_nettype wire

//--- front_panel_tb.sv
// Testbench for the front-panel display path with random CPU and APB stimulus checked
// against a cycle model of the lamps. Run it through the Makefile with Verilator.
`default_nettype none

module front_panel_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period    = 20;
    localparam int reset_cycles  = 5;
    localparam int n_state_steps = 300;
    localparam int n_sel_steps   = 12;
    localparam int n_err_xfers   = 40;
    localparam int xfer_cycles   = 2;
    // Clock budget for the whole run, doubled as margin
    localparam int budget_cycles = 2 * (reset_cycles + xfer_cycles + n_state_steps
        + 8 * (3 * xfer_cycles + 2 + n_sel_steps)
        + n_err_xfers * 2 * xfer_cycles + 10);

    logic clk = 1'b0;
    logic rst_n;
    panel_pkg::cpu_view_t    cpu_view;
    panel_pkg::apb_req_t     apb;
    panel_pkg::apb_rsp_t     apb_rsp;
    panel_pkg::panel_lamps_t lamps;

    integer seed;

    // Reference model registers
    panel_pkg::major_flags_t m_flags;
    logic [2:0]              m_dsel;
    panel_pkg::panel_lamps_t m_lamps;

    front_panel front_panel_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_view (cpu_view),
        .apb      (apb),
        .apb_rsp  (apb_rsp),
        .lamps    (lamps)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic panel_pkg::major_flags_t next_flags(
        panel_pkg::major_flags_t cur, logic [4:0] st, logic run);
        panel_pkg::major_flags_t nf;
        nf = '0;
        case (st)
            // F0 only moves the Fetch lamp
            panel_pkg::st_f0: begin
                nf    = cur;
                nf.fs = run;
            end
            panel_pkg::st_fw, panel_pkg::st_f1, panel_pkg::st_f2, panel_pkg::st_f3,
            panel_pkg::st_f2a, panel_pkg::st_f2b: nf.fs = 1'b1;
            panel_pkg::st_d0, panel_pkg::st_dw, panel_pkg::st_d1, panel_pkg::st_d2,
            panel_pkg::st_d3: nf.ds = 1'b1;
            panel_pkg::st_e0, panel_pkg::st_ew, panel_pkg::st_e1, panel_pkg::st_e2,
            panel_pkg::st_e3, panel_pkg::st_eae0, panel_pkg::st_eae1: nf.es = 1'b1;
            default: nf = '0;
        endcase
        return nf;
    endfunction

    function automatic logic [11:0] word_for(logic [2:0] sel, panel_pkg::major_flags_t f,
                                             panel_pkg::cpu_view_t v);
        case (sel)
            3'd1:    return v.status;
            3'd2:    return v.ac;
            3'd3:    return v.mb;
            3'd4:    return v.mq;
            3'd5:    return v.io_bus;
            default: return {f.fs, f.ds, f.es, v.state1};
        endcase
    endfunction

    function automatic logic [4:0] pattern_for(logic [2:0] sel);
        case (sel)
            3'd1:    return 5'b01010;
            3'd2:    return 5'b01001;
            3'd3:    return 5'b10100;
            3'd4:    return 5'b10010;
            3'd5:    return 5'b10001;
            default: return 5'b01100;
        endcase
    endfunction

    // Lamps are computed from the old flags and selection before those advance
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_flags = '0;
            m_dsel  = panel_pkg::dsel_state;
            m_lamps = '0;
        end else begin
            m_lamps.dout     = word_for(m_dsel, m_flags, cpu_view);
            m_lamps.dsel_led = pattern_for(m_dsel);
            m_lamps.run_led  = cpu_view.run_ff ^ cpu_view.sw_active;
            m_flags = next_flags(m_flags, cpu_view.state, cpu_view.run_ff);
            if (apb.psel && apb.penable && apb.pwrite && apb.paddr == panel_pkg::reg_ctrl) begin
                m_dsel = apb.pwdata[2:0];
            end
        end
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic randomize_cpu();
        logic [31:0] r;
        r = $random(seed);
        // Bias toward F0 so the hold behavior is exercised often
        if (r[31:30] == 2'b00) begin
            cpu_view.state = panel_pkg::st_f0;
        end else begin
            cpu_view.state = r[4:0];
        end
        cpu_view.state1    = r[13:5];
        cpu_view.run_ff    = r[14];
        cpu_view.sw_active = r[15];
        r = $random(seed);
        cpu_view.status = r[11:0];
        cpu_view.ac     = r[23:12];
        r = $random(seed);
        cpu_view.mb = r[11:0];
        cpu_view.mq = r[23:12];
        r = $random(seed);
        cpu_view.io_bus = r[11:0];
    endtask

    // Waits for a falling edge, compares the lamps with the model and drives new inputs
    task automatic next_cycle();
        @(negedge clk);
        check_value("lamps", 32'(lamps), 32'(m_lamps));
        randomize_cpu();
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    // Samples the response halfway into the low phase of the access cycle
    task automatic apb_xfer(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        next_cycle();
        apb.psel    = 1'b1;
        apb.pwrite  = write;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        next_cycle();
        apb.psel    = 1'b1;
        apb.penable = 1'b1;
        #(clk_period / 4);
        check_value("pready", 32'(apb_rsp.pready), 32'd1);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
    endtask

    initial begin
        #(budget_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d clock cycles", budget_cycles);
        $display("ERRORS FOUND");
        $fatal(1);
    end

    initial begin
        logic [31:0]             rdata;
        logic                    err;
        logic [31:0]             r;
        logic [2:0]              last_sel;
        logic [3:0]              addr;
        logic                    write;

        seed     = 36404;
        rst_n    = 1'b0;
        cpu_view = '0;
        apb      = '0;
        repeat (reset_cycles) @(negedge clk);
        check_value("lamps", 32'(lamps), 32'd0);
        rst_n = 1'b1;

        // Reset state seen through the register file
        apb_xfer(1'b0, panel_pkg::reg_ctrl, 32'd0, rdata, err);
        check_value("reg_ctrl", rdata, 32'(panel_pkg::dsel_state));
        check_value("pslverr", 32'(err), 32'd0);

        // Random major states with the state word on display
        repeat (n_state_steps) next_cycle();

        for (int sel = 0; sel < 8; sel++) begin
            r = $random(seed);
            apb_xfer(1'b1, panel_pkg::reg_ctrl, {r[31:3], 3'(sel)}, rdata, err);
            check_value("pslverr", 32'(err), 32'd0);
            last_sel = 3'(sel);
            // The access edge loads dsel and the following edge loads the lamps
            next_cycle();
            next_cycle();
            check_value("dsel_led", 32'(lamps.dsel_led), 32'(pattern_for(last_sel)));
            apb_xfer(1'b0, panel_pkg::reg_ctrl, 32'd0, rdata, err);
            check_value("reg_ctrl", rdata, 32'(last_sel));
            apb_xfer(1'b0, panel_pkg::reg_lamps, 32'd0, rdata, err);
            // The model still holds the lamps of the access cycle
            check_value("reg_lamps", rdata, 32'(m_lamps));
            check_value("pslverr", 32'(err), 32'd0);
            repeat (n_sel_steps) next_cycle();
        end

        // Unmapped addresses and writes to the lamp word
        for (int i = 0; i < n_err_xfers; i++) begin
            r = $random(seed);
            if (r[5:4] == 2'b00) begin
                addr  = panel_pkg::reg_lamps;
                write = 1'b1;
            end else begin
                addr  = r[3:0];
                write = r[6];
                if (addr == panel_pkg::reg_ctrl || addr == panel_pkg::reg_lamps) begin
                    addr = addr + 4'd1;
                end
            end
            apb_xfer(write, addr, $random(seed), rdata, err);
            check_value("pslverr", 32'(err), 32'd1);
            apb_xfer(1'b0, panel_pkg::reg_ctrl, 32'd0, rdata, err);
            check_value("reg_ctrl", rdata, 32'(last_sel));
        end

        next_cycle();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
panel_pkg.sv
major_state_decode.sv
display_mux.sv
panel_apb_regs.sv
front_panel.sv
front_panel_tb.sv

//--- Makefile
# Verilator build and run for the front-panel testbench

VERILATOR ?= verilator
TOP       ?= front_panel_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator status is ignored here, the log decides pass or fail
run: $(BIN)
	-$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^NO ERRORS$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
